//--- logic/flow_pkg.sv
// ################################################
// Descriptor, DAT and response layouts of the command flow
// Only the fields used by the immediate I2C write path are named
// ################################################
`default_nettype none

package flow_pkg;

  // Command attribute field of every descriptor
  typedef enum logic [2:0] {
    cmd_attr_regular          = 3'd0,
    cmd_attr_immediate        = 3'd1,
    cmd_attr_addr_assign      = 3'd2,
    cmd_attr_combo            = 3'd3,
    cmd_attr_internal_control = 3'd7
  } cmd_attr_e;

  // Fields common to all command types
  typedef struct packed {
    logic [63:30] rsvd_63_30;
    logic         rnw;
    logic [28:21] rsvd_28_21;
    logic [4:0]   dev_idx;
    logic [15:7]  rsvd_15_7;
    logic [3:0]   tid;
    cmd_attr_e    attr;
  } cmd_generic_t;

  // Immediate data transfer, up to four bytes inside the descriptor
  typedef struct packed {
    logic [7:0]   data_byte4;
    logic [7:0]   data_byte3;
    logic [7:0]   data_byte2;
    logic [7:0]   def_or_data_byte1;
    logic         toc;
    logic [30:26] rsvd_30_26;
    logic [2:0]   dtt;
    logic [22:7]  rsvd_22_7;
    logic [3:0]   tid;
    cmd_attr_e    attr;
  } cmd_imm_t;

  typedef union packed {
    cmd_generic_t generic;
    cmd_imm_t     imm;
  } cmd_desc_u;

  typedef struct packed {
    logic [63:32] rsvd_63_32;
    logic         device;
    logic [30:7]  rsvd_30_7;
    logic [6:0]   static_address;
  } dat_entry_t;

  typedef enum logic [3:0] {
    resp_success       = 4'h0,
    resp_not_supported = 4'hC
  } resp_err_e;

  typedef struct packed {
    resp_err_e   err_status;
    logic [3:0]  tid;
    logic [7:0]  rsvd_23_16;
    logic [15:0] data_length;
  } resp_desc_t;

  // Target address byte only, no broadcast address in front
  localparam int unsigned bytes_before_imm_data = 1;

endpackage

`default_nettype wire

//--- logic/dat_if.sv
// ################################################
// One DAT read in flight at a time
// ################################################
`timescale 1ns/1ns
`default_nettype none

interface dat_if #(
  parameter int unsigned dat_depth = 32
) ();

  localparam int unsigned idx_w = $clog2(dat_depth);

  // Single cycle request, index held until done
  logic                   req;
  logic [idx_w-1:0]       index;
  logic                   done;
  flow_pkg::dat_entry_t   entry;

  modport sequencer (output req, output index, input done, input entry);
  modport lookup (input req, input index, output done, output entry);

endinterface

`default_nettype wire

//--- logic/imm_xfer_if.sv
// ################################################
// Start is a single pulse, inputs held until done
// Data length is at most 4 bytes
// ################################################
`timescale 1ns/1ns
`default_nettype none

interface imm_xfer_if ();

  logic               start;
  flow_pkg::cmd_imm_t desc;
  logic [6:0]         static_addr;
  // Payload bytes after the address, defining byte excluded
  logic [2:0]         data_len;
  logic               done;

  modport sequencer (
    output start,
    output desc,
    output static_addr,
    output data_len,
    input  done
  );

  modport formatter (
    input  start,
    input  desc,
    input  static_addr,
    input  data_len,
    output done
  );

endinterface

`default_nettype wire

//--- logic/dat_lookup.sv
// ################################################
// Table must return read data one cycle after the request
// ################################################
`timescale 1ns/1ns
`default_nettype none

module dat_lookup #(
  parameter int unsigned dat_depth = 32
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  dat_if.lookup                             dat,
  output logic                              dat_read_valid_o,
  output logic [$clog2(dat_depth)-1:0]      dat_index_o,
  input  wire logic [63:0]                  dat_rdata_i
);

  logic                 rd_pending_q;
  logic                 done_q;
  flow_pkg::dat_entry_t entry_q;

  // Request goes straight to the table
  assign dat_read_valid_o = dat.req;
  assign dat_index_o      = dat.index;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      rd_pending_q <= dat.req;
      done_q       <= rd_pending_q;
    end
  end

  // Entry stays valid until the next read
  always_ff @(posedge clk_i) begin
    if (rd_pending_q) begin
      entry_q <= flow_pkg::dat_entry_t'(dat_rdata_i);
    end
  end

  assign dat.done  = done_q;
  assign dat.entry = entry_q;

endmodule

`default_nettype wire

//--- logic/imm_byte_formatter.sv
// ################################################
// Write direction only, read bit of the address byte is 0
// ################################################
`timescale 1ns/1ns
`default_nettype none

module imm_byte_formatter (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  imm_xfer_if.formatter xfer,
  output logic       fmt_valid_o,
  input  wire logic  fmt_ready_i,
  output logic [7:0] fmt_byte_o,
  output logic       fmt_start_o,
  output logic       fmt_stop_o
);

  logic       busy_q;
  logic       done_q;
  logic [2:0] cnt_q;
  logic [2:0] last_cnt;
  logic [2:0] data_sel;
  logic       use_def_byte;
  logic       handshake;
  logic       last_byte;

  // DTT of 5 to 7 puts a defining byte in data byte 1
  assign use_def_byte = xfer.desc.dtt > 3'd4;

  assign last_cnt  = xfer.data_len + 3'(flow_pkg::bytes_before_imm_data) - 3'd1;
  assign last_byte = cnt_q == last_cnt;
  assign handshake = busy_q & fmt_ready_i;

  // Position among data bytes 1 to 4
  assign data_sel = cnt_q - 3'(flow_pkg::bytes_before_imm_data) + {2'b00, use_def_byte};

  always_comb begin
    if (cnt_q < 3'(flow_pkg::bytes_before_imm_data)) begin
      fmt_byte_o = {xfer.static_addr, 1'b0};
    end else begin
      case (data_sel)
        3'd0:    fmt_byte_o = xfer.desc.def_or_data_byte1;
        3'd1:    fmt_byte_o = xfer.desc.data_byte2;
        3'd2:    fmt_byte_o = xfer.desc.data_byte3;
        3'd3:    fmt_byte_o = xfer.desc.data_byte4;
        default: fmt_byte_o = 8'h00;
      endcase
    end
  end

  assign fmt_valid_o = busy_q;
  assign fmt_start_o = cnt_q == 3'd0;
  // Stop only if the command asks for it
  assign fmt_stop_o  = last_byte & xfer.desc.toc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= 3'd0;
      done_q <= 1'b0;
    end else begin
      done_q <= handshake & last_byte;
      if (xfer.start) begin
        busy_q <= 1'b1;
        cnt_q  <= 3'd0;
      end else if (handshake) begin
        if (last_byte) begin
          busy_q <= 1'b0;
          cnt_q  <= 3'd0;
        end else begin
          cnt_q <= cnt_q + 3'd1;
        end
      end
    end
  end

  assign xfer.done = done_q;

endmodule

`default_nettype wire

//--- logic/flow_sequencer.sv
// ################################################
// Only immediate writes to legacy I2C devices reach the bus
// Anything else is answered with not_supported
// ################################################
`timescale 1ns/1ns
`default_nettype none

module flow_sequencer #(
  parameter int unsigned dat_depth = 32
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 fsm_en_i,
  output logic                      fsm_idle_o,
  input  wire logic                 cmd_queue_rvalid_i,
  output logic                      cmd_queue_rready_o,
  input  wire flow_pkg::cmd_desc_u  cmd_queue_rdata_i,
  dat_if.sequencer                  dat,
  imm_xfer_if.sequencer             xfer,
  output logic                      resp_queue_wvalid_o,
  input  wire logic                 resp_queue_wready_i,
  output flow_pkg::resp_desc_t      resp_queue_wdata_o
);

  localparam int unsigned idx_w = $clog2(dat_depth);

  typedef enum logic [2:0] {
    st_idle,
    st_wait_cmd,
    st_fetch_dat,
    st_xfer,
    st_write_resp
  } state_e;

  state_e              state_q, state_d;
  flow_pkg::cmd_desc_u desc_q;
  flow_pkg::resp_err_e status_q, status_d;
  logic                dat_req_q;
  logic                cmd_accept;
  logic                dispatch;
  logic [2:0]          dtt;

  assign cmd_accept = cmd_queue_rvalid_i & cmd_queue_rready_o;
  assign dtt        = desc_q.imm.dtt;

  // Bus traffic only for immediate commands to I2C devices
  assign dispatch = (desc_q.generic.attr == flow_pkg::cmd_attr_immediate) & dat.entry.device;

  assign fsm_idle_o          = state_q == st_idle;
  assign cmd_queue_rready_o  = state_q == st_wait_cmd;
  assign resp_queue_wvalid_o = state_q == st_write_resp;

  // DAT read one cycle after acceptance
  assign dat.req   = dat_req_q;
  assign dat.index = idx_w'(desc_q.generic.dev_idx);

  assign xfer.start       = (state_q == st_fetch_dat) & dat.done & dispatch;
  assign xfer.desc        = desc_q.imm;
  assign xfer.static_addr = dat.entry.static_address;
  assign xfer.data_len    = (dtt > 3'd4) ? dtt - 3'd5 : dtt;

  always_comb begin
    resp_queue_wdata_o.err_status  = status_q;
    resp_queue_wdata_o.tid         = desc_q.generic.tid;
    resp_queue_wdata_o.rsvd_23_16  = 8'h00;
    // Nothing is read back
    resp_queue_wdata_o.data_length = 16'h0000;
  end

  always_comb begin
    state_d  = state_q;
    status_d = status_q;
    case (state_q)
      st_idle: begin
        if (fsm_en_i) begin
          state_d = st_wait_cmd;
        end
      end
      st_wait_cmd: begin
        if (cmd_accept) begin
          state_d = st_fetch_dat;
        end
      end
      st_fetch_dat: begin
        if (dat.done) begin
          if (dispatch) begin
            state_d  = st_xfer;
            status_d = flow_pkg::resp_success;
          end else begin
            state_d  = st_write_resp;
            status_d = flow_pkg::resp_not_supported;
          end
        end
      end
      st_xfer: begin
        if (xfer.done) begin
          state_d = st_write_resp;
        end
      end
      st_write_resp: begin
        if (resp_queue_wready_i) begin
          state_d = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= st_idle;
      status_q  <= flow_pkg::resp_success;
      dat_req_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      status_q  <= status_d;
      dat_req_q <= cmd_accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      desc_q <= cmd_queue_rdata_i;
    end
  end

endmodule

`default_nettype wire

//--- logic/flow_active_top.sv
// ################################################
// External DAT answers reads one cycle after the request
// ################################################
`timescale 1ns/1ns
`default_nettype none

module flow_active_top #(
  parameter int unsigned dat_depth = 32
) (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         fsm_en_i,
  output logic                              fsm_idle_o,
  input  wire logic                         cmd_queue_rvalid_i,
  output logic                              cmd_queue_rready_o,
  input  wire logic [63:0]                  cmd_queue_rdata_i,
  output logic                              dat_read_valid_o,
  output logic [$clog2(dat_depth)-1:0]      dat_index_o,
  input  wire logic [63:0]                  dat_rdata_i,
  output logic                              fmt_valid_o,
  input  wire logic                         fmt_ready_i,
  output logic [7:0]                        fmt_byte_o,
  output logic                              fmt_start_o,
  output logic                              fmt_stop_o,
  output logic                              resp_queue_wvalid_o,
  input  wire logic                         resp_queue_wready_i,
  output logic [31:0]                       resp_queue_wdata_o
);

  dat_if #(.dat_depth(dat_depth)) dat_bus ();
  imm_xfer_if xfer_bus ();

  flow_sequencer #(
    .dat_depth(dat_depth)
  ) flow_sequencer_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fsm_en_i            (fsm_en_i),
    .fsm_idle_o          (fsm_idle_o),
    .cmd_queue_rvalid_i  (cmd_queue_rvalid_i),
    .cmd_queue_rready_o  (cmd_queue_rready_o),
    .cmd_queue_rdata_i   (cmd_queue_rdata_i),
    .dat                 (dat_bus.sequencer),
    .xfer                (xfer_bus.sequencer),
    .resp_queue_wvalid_o (resp_queue_wvalid_o),
    .resp_queue_wready_i (resp_queue_wready_i),
    .resp_queue_wdata_o  (resp_queue_wdata_o)
  );

  dat_lookup #(
    .dat_depth(dat_depth)
  ) dat_lookup_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dat              (dat_bus.lookup),
    .dat_read_valid_o (dat_read_valid_o),
    .dat_index_o      (dat_index_o),
    .dat_rdata_i      (dat_rdata_i)
  );

  imm_byte_formatter imm_byte_formatter_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .xfer        (xfer_bus.formatter),
    .fmt_valid_o (fmt_valid_o),
    .fmt_ready_i (fmt_ready_i),
    .fmt_byte_o  (fmt_byte_o),
    .fmt_start_o (fmt_start_o),
    .fmt_stop_o  (fmt_stop_o)
  );

endmodule

`default_nettype wire

//--- dv/flow_tb_ref.svh
// ################################################
// Expected bytes and response of one command
// Included inside the testbench module
// ################################################
`ifndef FLOW_TB_REF_SVH
`define FLOW_TB_REF_SVH

// Up to five entries of {start, stop, byte}, entry 0 in the low bits
typedef struct packed {
  logic [2:0]  n_bytes;
  logic [49:0] bytes;
  logic [31:0] resp;
} expect_t;

function automatic expect_t expected_result(logic [63:0] desc, logic [63:0] entry);
  expect_t    res;
  logic [2:0] dtt;
  int         len;
  int         first;
  dtt      = desc[25:23];
  res      = '0;
  res.resp = {4'hC, desc[6:3], 24'h000000};
  // Immediate attribute and a legacy I2C device
  if (desc[2:0] == 3'd1 && entry[31]) begin
    len   = (dtt <= 3'd4) ? int'(dtt) : int'(dtt) - 5;
    // Data byte 1 is the defining byte for DTT 5 to 7
    first = (dtt <= 3'd4) ? 1 : 2;
    res.n_bytes    = 3'(len + 1);
    res.bytes[9:0] = {1'b1, desc[31] && (len == 0), entry[6:0], 1'b0};
    for (int i = 1; i <= len; i++) begin
      res.bytes[i*10 +: 10] = {1'b0, desc[31] && (i == len), desc[32 + 8*(first+i-2) +: 8]};
    end
    res.resp = {4'h0, desc[6:3], 24'h000000};
  end
  return res;
endfunction

task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
  if (got !== exp) begin
    $display("** Error: %s got %h, expected %h", name, got, exp);
    fail_count++;
    stop_on_failure("a value mismatch");
  end
endtask

// Failures that have no single wrong value, timeouts among them
task automatic report_problem(string what);
  $display("Failure: %s", what);
  fail_count++;
  stop_on_failure(what);
endtask

`endif

//--- dv/flow_active_tb.sv
// ################################################
// DAT model answers one cycle after a read request
// One command in flight at a time
// ################################################
`timescale 1ns/1ns
`default_nettype none

module flow_active_tb;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        fsm_en_i;
  logic        fsm_idle_o;
  logic        cmd_queue_rvalid_i;
  logic        cmd_queue_rready_o;
  logic [63:0] cmd_queue_rdata_i;
  logic        dat_read_valid_o;
  logic [4:0]  dat_index_o;
  logic [63:0] dat_rdata_i;
  logic        fmt_valid_o;
  logic        fmt_ready_i;
  logic [7:0]  fmt_byte_o;
  logic        fmt_start_o;
  logic        fmt_stop_o;
  logic        resp_queue_wvalid_o;
  logic        resp_queue_wready_i;
  logic [31:0] resp_queue_wdata_o;

  logic [63:0] dat_table [0:31];
  logic [9:0]  exp_byte_q [$];
  logic [31:0] exp_resp_q [$];
  logic [4:0]  exp_idx_q [$];
  logic        dat_pend;
  logic [4:0]  dat_pend_idx;
  logic        stall_en;
  int          fail_count;
  int          resp_count;

  task automatic stop_on_failure(string why);
    $display("Simulation failed");
    $fatal(1, "Stopped after %s", why);
  endtask

  `include "flow_tb_ref.svh"

  flow_active_top #(.dat_depth(32)) flow_active_top_i (.*);

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  // Ready stalls and DAT read data
  always @(negedge clk_i) begin
    fmt_ready_i         <= !stall_en || ($urandom % 3 != 0);
    resp_queue_wready_i <= !stall_en || ($urandom % 3 != 0);
    dat_rdata_i         <= dat_pend ? dat_table[dat_pend_idx] : 64'h0;
  end

  // Comparison of every handshake with the expected queues
  always @(posedge clk_i) begin
    logic [9:0] exp_b;
    dat_pend <= 1'b0;
    if (rst_ni) begin
      if (dat_read_valid_o) begin
        if (exp_idx_q.size() == 0) begin
          report_problem("DAT read without a pending command");
        end
        compare_value("dat_index_o", dat_index_o, exp_idx_q.pop_front());
        dat_pend     <= 1'b1;
        dat_pend_idx <= dat_index_o;
      end
      if (fmt_valid_o && fmt_ready_i) begin
        if (exp_byte_q.size() == 0) begin
          report_problem("format FIFO byte that was not expected");
        end
        exp_b = exp_byte_q.pop_front();
        compare_value("fmt_start_o", fmt_start_o, exp_b[9]);
        compare_value("fmt_stop_o", fmt_stop_o, exp_b[8]);
        compare_value("fmt_byte_o", fmt_byte_o, exp_b[7:0]);
      end
      if (resp_queue_wvalid_o && resp_queue_wready_i) begin
        if (exp_resp_q.size() == 0 || exp_byte_q.size() != 0) begin
          report_problem("response without a command or before all bytes were sent");
        end
        compare_value("resp_queue_wdata_o", resp_queue_wdata_o, exp_resp_q.pop_front());
        resp_count++;
      end
    end
  end

  function automatic logic [63:0] build_desc(logic [2:0] attr, logic [4:0] idx,
                                             logic [2:0] dtt, logic toc);
    logic [63:0] desc;
    desc        = {$urandom, $urandom};
    desc[2:0]   = attr;
    desc[20:16] = idx;
    desc[25:23] = dtt;
    desc[31]    = toc;
    return desc;
  endfunction

  // Called and returns on a falling edge
  task automatic run_command(logic [63:0] desc);
    expect_t exp;
    int      wait_cnt;
    int      target;
    exp = expected_result(desc, dat_table[desc[20:16]]);
    for (int i = 0; i < exp.n_bytes; i++) begin
      exp_byte_q.push_back(exp.bytes[i*10 +: 10]);
    end
    exp_resp_q.push_back(exp.resp);
    exp_idx_q.push_back(desc[20:16]);
    target             = resp_count + 1;
    cmd_queue_rvalid_i = 1'b1;
    cmd_queue_rdata_i  = desc;
    wait_cnt           = 0;
    do begin
      @(posedge clk_i);
      wait_cnt++;
      if (wait_cnt > 50) begin
        report_problem("command was not accepted in time");
      end
    end while (!cmd_queue_rready_o);
    @(negedge clk_i);
    cmd_queue_rvalid_i = 1'b0;
    wait_cnt           = 0;
    while (resp_count != target) begin
      @(negedge clk_i);
      wait_cnt++;
      if (wait_cnt > 200) begin
        report_problem("no response for the accepted command");
      end
    end
  endtask

  initial begin
    logic [2:0] attr;
    void'($urandom(13722));
    rst_ni              = 1'b0;
    fsm_en_i            = 1'b0;
    cmd_queue_rvalid_i  = 1'b0;
    cmd_queue_rdata_i   = 64'h0;
    dat_rdata_i         = 64'h0;
    fmt_ready_i         = 1'b1;
    resp_queue_wready_i = 1'b1;
    stall_en            = 1'b0;
    dat_pend            = 1'b0;
    fail_count          = 0;
    resp_count          = 0;
    for (int i = 0; i < 32; i++) begin
      dat_table[i] = {$urandom, $urandom};
    end
    dat_table[3][31] = 1'b1;
    dat_table[4][31] = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni             = 1'b1;
    // Disabled flow ignores a waiting command
    cmd_queue_rvalid_i = 1'b1;
    repeat (10) begin
      @(negedge clk_i);
      compare_value("fsm_idle_o", fsm_idle_o, 1);
      compare_value("cmd_queue_rready_o", cmd_queue_rready_o, 0);
      compare_value("dat_read_valid_o", dat_read_valid_o, 0);
      compare_value("fmt_valid_o", fmt_valid_o, 0);
      compare_value("resp_queue_wvalid_o", resp_queue_wvalid_o, 0);
    end
    cmd_queue_rvalid_i = 1'b0;
    fsm_en_i           = 1'b1;
    for (int d = 0; d < 8; d++) begin
      run_command(build_desc(3'd1, 5'd3, 3'(d), 1'b0));
      run_command(build_desc(3'd1, 5'd3, 3'(d), 1'b1));
    end
    run_command(build_desc(3'd0, 5'd3, 3'd2, 1'b1));
    run_command(build_desc(3'd3, 5'd3, 3'd2, 1'b1));
    run_command(build_desc(3'd1, 5'd4, 3'd3, 1'b1));
    stall_en = 1'b1;
    repeat (200) begin
      case ($urandom % 6)
        0:       attr = 3'd0;
        1:       attr = 3'd3;
        2:       attr = 3'd2;
        3:       attr = 3'd7;
        default: attr = 3'd1;
      endcase
      run_command(build_desc(attr, 5'($urandom), 3'($urandom), 1'($urandom)));
    end
    if (exp_byte_q.size() != 0 || exp_idx_q.size() != 0 || resp_count != 219) begin
      report_problem("expected traffic left over at the end");
    end
    if (fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      stop_on_failure("failed checks");
    end
  end

endmodule

`default_nettype wire

//--- flow_active.f
+incdir+dv
logic/flow_pkg.sv
logic/dat_if.sv
logic/imm_xfer_if.sv
logic/dat_lookup.sv
logic/imm_byte_formatter.sv
logic/flow_sequencer.sv
logic/flow_active_top.sv
dv/flow_active_tb.sv
